// ==== include/fc_cfg.svh ====
`ifndef FC_CFG_SVH
`define FC_CFG_SVH

////////////////////
// array shape

`define FC_LANES    4   // lanes, also outputs per run
`define FC_DATA_W   8   // int8 feature, weight and output
`define FC_PROD_W   16  // signed 8x8 product
`define FC_ACC_W    28  // accumulator and bias-added sum

////////////////////
// buffers

`define FC_DEPTH    64
`define FC_ADDR_W   6
`define FC_LEN_W    7   // holds 1 to 64

////////////////////
// requantization and pipeline

`define FC_QSHIFT   6   // output = sum >> 6
`define FC_QTOP     12  // any set bit above this saturates to 127
`define FC_MUL_LAT  3   // multiplier stages

`endif

// ==== src/fc_pkg.sv ====
`include "fc_cfg.svh"

package fc_pkg;

  // one int8 value
  typedef logic signed [`FC_DATA_W-1:0] data_t;

  // four int8 values, lane j in bits 8j+7:8j
  typedef logic [`FC_LANES*`FC_DATA_W-1:0] word_t;

  typedef logic signed [`FC_PROD_W-1:0] prod_t;
  typedef logic signed [`FC_ACC_W-1:0]  acc_t;

  typedef logic [`FC_ADDR_W-1:0] addr_t;
  typedef logic [`FC_LEN_W-1:0]  len_t;

  // run sequencer
  typedef enum logic {
    FEED_IDLE,
    FEED_RUN
  } feed_state_t;

endpackage

// ==== src/fc_feeder.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module fc_feeder (
  input  logic          clk,
  input  logic          rstn,
  input  logic          feat_we,
  input  fc_pkg::addr_t feat_addr,
  input  fc_pkg::data_t feat_data,
  input  logic          w_we,
  input  fc_pkg::addr_t w_addr,
  input  fc_pkg::word_t w_data,
  input  logic          start,
  input  fc_pkg::len_t  feat_len,
  output logic          ready,
  output fc_pkg::data_t feat,
  output logic          valid,
  output logic          first,
  output logic          last,
  output fc_pkg::word_t lane_w
);
  import fc_pkg::*;

  data_t       feat_mem [`FC_DEPTH];
  word_t       w_mem [`FC_DEPTH];
  feed_state_t state;
  addr_t       idx;       // read index of the current run
  len_t        len_q;
  word_t       w_q;       // weight word read with the feature
  data_t       lane_w_a [`FC_LANES];
  logic        issue;
  logic        at_end;

  assign issue  = (state == FEED_RUN);
  assign at_end = (len_t'(idx) == len_q - len_t'(1));
  assign ready  = (state == FEED_IDLE);

  ////////////////////
  // run sequencer

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= FEED_IDLE;
      idx   <= '0;
      len_q <= '0;
      valid <= 1'b0;
      first <= 1'b0;
      last  <= 1'b0;
    end else begin
      case (state)
        FEED_IDLE: begin
          if (start) begin
            state <= FEED_RUN;
            idx   <= '0;
            len_q <= feat_len;
          end
        end
        FEED_RUN: begin
          if (at_end) state <= FEED_IDLE;
          else        idx   <= idx + addr_t'(1);
        end
        default: state <= FEED_IDLE;
      endcase
      // flags line up with the registered read data
      valid <= issue;
      first <= issue && (idx == '0);
      last  <= issue && at_end;
    end
  end

  ////////////////////
  // buffers

  always_ff @(posedge clk) begin
    if (feat_we) feat_mem[feat_addr] <= feat_data;
    if (w_we)    w_mem[w_addr]       <= w_data;
    feat <= feat_mem[idx];  // synchronous read
    w_q  <= w_mem[idx];
  end

  // lane j weight waits j cycles for the feature to walk the chain
  for (genvar j = 0; j < `FC_LANES; j++) begin : g_skew
    if (j == 0) begin : g_direct
      assign lane_w_a[j] = w_q[`FC_DATA_W-1:0];
    end else begin : g_delay
      data_t pipe [j];
      always_ff @(posedge clk) begin
        pipe[0] <= w_q[j*`FC_DATA_W +: `FC_DATA_W];
        for (int k = 1; k < j; k++) begin
          pipe[k] <= pipe[k-1];
        end
      end
      assign lane_w_a[j] = pipe[j-1];
    end
  end

  always_comb begin
    for (int j = 0; j < `FC_LANES; j++) begin
      lane_w[j*`FC_DATA_W +: `FC_DATA_W] = lane_w_a[j];
    end
  end

  // buffers must stay still while a run reads them
  a_no_write_in_run: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == FEED_RUN) |-> !(feat_we || w_we)
  );

endmodule

// ==== src/fc_mult.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module fc_mult (
  input  logic          clk,
  input  logic          rstn,
  input  fc_pkg::data_t a,
  input  fc_pkg::data_t b,
  output fc_pkg::prod_t p
);
  import fc_pkg::*;

  localparam int NPAIR = `FC_DATA_W / 2;

  logic [`FC_DATA_W-1:0]   a_mag;
  logic [`FC_DATA_W-1:0]   b_mag;
  logic [`FC_DATA_W-1:0]   pp_q [`FC_DATA_W];   // gated partial products
  logic [`FC_DATA_W+1:0]   pair_q [NPAIR];
  logic [`FC_PROD_W-1:0]   mag_sum;
  logic                    sign_s1;
  logic                    sign_s2;

  // -128 becomes 8'h80, still exact as unsigned
  assign a_mag = a[`FC_DATA_W-1] ? `FC_DATA_W'(-a) : `FC_DATA_W'(a);
  assign b_mag = b[`FC_DATA_W-1] ? `FC_DATA_W'(-b) : `FC_DATA_W'(b);

  ////////////////////
  // stage 1 partial products

  always_ff @(posedge clk) begin
    for (int i = 0; i < `FC_DATA_W; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
  end

  ////////////////////
  // stage 2 pair sums

  always_ff @(posedge clk) begin
    for (int k = 0; k < NPAIR; k++) begin
      pair_q[k] <= (`FC_DATA_W+2)'(pp_q[2*k]) + ((`FC_DATA_W+2)'(pp_q[2*k+1]) << 1);
    end
  end

  ////////////////////
  // stage 3 final sum and sign fix

  always_comb begin
    mag_sum = '0;
    for (int k = 0; k < NPAIR; k++) begin
      mag_sum = mag_sum + (`FC_PROD_W'(pair_q[k]) << (2*k));
    end
  end

  always_ff @(posedge clk) begin
    p <= sign_s2 ? prod_t'(-mag_sum) : prod_t'(mag_sum);
  end

  // sign rides along with stages 1 and 2
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sign_s1 <= 1'b0;
      sign_s2 <= 1'b0;
    end else begin
      sign_s1 <= a[`FC_DATA_W-1] ^ b[`FC_DATA_W-1];
      sign_s2 <= sign_s1;
    end
  end

endmodule

// ==== src/fc_pe.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module fc_pe (
  input  logic          clk,
  input  logic          rstn,
  input  fc_pkg::data_t feat_in,
  input  logic          valid_in,
  input  logic          first_in,
  input  logic          last_in,
  input  fc_pkg::data_t weight,
  output fc_pkg::data_t feat_out,
  output logic          valid_out,
  output logic          first_out,
  output logic          last_out,
  output fc_pkg::acc_t  acc,
  output logic          acc_valid
);
  import fc_pkg::*;

  localparam int LAT = `FC_MUL_LAT;

  prod_t          prod;
  logic [LAT-1:0] v_d;   // flags delayed alongside the multiplier
  logic [LAT-1:0] f_d;
  logic [LAT-1:0] l_d;

  fc_mult u_mult (
    .clk  (clk),
    .rstn (rstn),
    .a    (feat_in),
    .b    (weight),
    .p    (prod)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_out <= 1'b0;
      first_out <= 1'b0;
      last_out  <= 1'b0;
      v_d       <= '0;
      f_d       <= '0;
      l_d       <= '0;
      acc_valid <= 1'b0;
    end else begin
      valid_out <= valid_in;  // one stage to the next lane
      first_out <= first_in;
      last_out  <= last_in;
      v_d       <= {v_d[LAT-2:0], valid_in};
      f_d       <= {f_d[LAT-2:0], first_in};
      l_d       <= {l_d[LAT-2:0], last_in};
      acc_valid <= v_d[LAT-1] && l_d[LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    feat_out <= feat_in;
  end

  // first item of a run restarts the sum
  always_ff @(posedge clk) begin
    if (v_d[LAT-1]) begin
      acc <= f_d[LAT-1] ? acc_t'(prod) : acc + acc_t'(prod);
    end
  end

  a_flags_need_valid: assert property (
    @(posedge clk) disable iff (!rstn)
    (first_in || last_in) |-> valid_in
  );

endmodule

// ==== src/fc_drain.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module fc_drain (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 bias_we,
  input  fc_pkg::word_t        bias_data,
  input  fc_pkg::acc_t         lane_acc [`FC_LANES],
  input  logic [`FC_LANES-1:0] lane_done,
  output logic                 out_valid,
  output fc_pkg::word_t        out_data
);
  import fc_pkg::*;

  word_t bias_q;
  acc_t  aligned [`FC_LANES];  // lane sums of one run, lined up with lane 3
  data_t q_out [`FC_LANES];

  always_ff @(posedge clk) begin
    if (bias_we) bias_q <= bias_data;
  end

  for (genvar j = 0; j < `FC_LANES; j++) begin : g_lane
    localparam int DLY = `FC_LANES - 1 - j;
    acc_t  v;
    data_t b;

    ////////////////////
    // de-skew

    if (DLY == 0) begin : g_last
      assign aligned[j] = lane_acc[j];
    end else begin : g_hold
      acc_t hold [DLY];
      // later stages keep the value while the next run reloads stage 0
      always_ff @(posedge clk) begin
        if (lane_done[j]) hold[0] <= lane_acc[j];
        for (int k = 1; k < DLY; k++) begin
          hold[k] <= hold[k-1];
        end
      end
      assign aligned[j] = hold[DLY-1];
    end

    ////////////////////
    // bias, relu, saturate

    assign b = bias_q[j*`FC_DATA_W +: `FC_DATA_W];
    assign v = aligned[j] + acc_t'(b);

    always_comb begin
      if (v[`FC_ACC_W-1]) begin
        q_out[j] = '0;                           // relu
      end else if (|v[`FC_ACC_W-2:`FC_QTOP+1]) begin
        q_out[j] = data_t'(8'sd127);             // clamp
      end else begin
        q_out[j] = {1'b0, v[`FC_QTOP:`FC_QSHIFT]};
      end
    end

    if (j > 0) begin : g_order
      a_lane_order: assert property (
        @(posedge clk) disable iff (!rstn)
        lane_done[j] |-> $past(lane_done[j-1])
      );
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) out_valid <= 1'b0;
    else       out_valid <= lane_done[`FC_LANES-1];
  end

  always_ff @(posedge clk) begin
    if (lane_done[`FC_LANES-1]) begin
      for (int j = 0; j < `FC_LANES; j++) begin
        out_data[j*`FC_DATA_W +: `FC_DATA_W] <= q_out[j];
      end
    end
  end

endmodule

// ==== src/fc_top.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module fc_top (
  input  logic          clk,
  input  logic          rstn,
  input  logic          feat_we,
  input  fc_pkg::addr_t feat_addr,
  input  fc_pkg::data_t feat_data,
  input  logic          w_we,
  input  fc_pkg::addr_t w_addr,
  input  fc_pkg::word_t w_data,
  input  logic          bias_we,
  input  fc_pkg::word_t bias_data,
  input  logic          start,
  input  fc_pkg::len_t  feat_len,
  output logic          ready,
  output logic          out_valid,
  output fc_pkg::word_t out_data
);
  import fc_pkg::*;

  // element j feeds lane j, the last one leaves the chain
  data_t                feat_c [`FC_LANES+1];
  logic [`FC_LANES:0]   valid_c;
  logic [`FC_LANES:0]   first_c;
  logic [`FC_LANES:0]   last_c;
  word_t                lane_w;
  acc_t                 lane_acc [`FC_LANES];
  logic [`FC_LANES-1:0] lane_done;

  fc_feeder u_feeder (
    .clk       (clk),
    .rstn      (rstn),
    .feat_we   (feat_we),
    .feat_addr (feat_addr),
    .feat_data (feat_data),
    .w_we      (w_we),
    .w_addr    (w_addr),
    .w_data    (w_data),
    .start     (start),
    .feat_len  (feat_len),
    .ready     (ready),
    .feat      (feat_c[0]),
    .valid     (valid_c[0]),
    .first     (first_c[0]),
    .last      (last_c[0]),
    .lane_w    (lane_w)
  );

  for (genvar j = 0; j < `FC_LANES; j++) begin : g_pe
    fc_pe u_pe (
      .clk       (clk),
      .rstn      (rstn),
      .feat_in   (feat_c[j]),
      .valid_in  (valid_c[j]),
      .first_in  (first_c[j]),
      .last_in   (last_c[j]),
      .weight    (lane_w[j*`FC_DATA_W +: `FC_DATA_W]),
      .feat_out  (feat_c[j+1]),
      .valid_out (valid_c[j+1]),
      .first_out (first_c[j+1]),
      .last_out  (last_c[j+1]),
      .acc       (lane_acc[j]),
      .acc_valid (lane_done[j])
    );
  end

  fc_drain u_drain (
    .clk       (clk),
    .rstn      (rstn),
    .bias_we   (bias_we),
    .bias_data (bias_data),
    .lane_acc  (lane_acc),
    .lane_done (lane_done),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rstn
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (16) @(posedge clk);  // held low for 16 cycles
    #2;
    rstn = 1'b1;
  end

endmodule

// ==== sim/tb_fc.sv ====
`timescale 1ns/1ns
`include "fc_cfg.svh"

module tb_fc;
  import fc_pkg::*;

  logic  clk;
  logic  rstn;
  logic  feat_we;
  addr_t feat_addr;
  data_t feat_data;
  logic  w_we;
  addr_t w_addr;
  word_t w_data;
  logic  bias_we;
  word_t bias_data;
  logic  start;
  len_t  feat_len;
  logic  ready;
  logic  out_valid;
  word_t out_data;

  int feat_v [`FC_DEPTH];          // model copy of the buffers
  int w_v [`FC_DEPTH][`FC_LANES];
  int bias_v [`FC_LANES];
  int seed = 51;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int mark = 0;                    // error count when the current test began

  tb_clock u_clock (.clk(clk), .rstn(rstn));

  fc_top dut (
    .clk       (clk),
    .rstn      (rstn),
    .feat_we   (feat_we),
    .feat_addr (feat_addr),
    .feat_data (feat_data),
    .w_we      (w_we),
    .w_addr    (w_addr),
    .w_data    (w_data),
    .bias_we   (bias_we),
    .bias_data (bias_data),
    .start     (start),
    .feat_len  (feat_len),
    .ready     (ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  ////////////////////
  // model

  function automatic int rand_byte(input int shift);
    logic [31:0] r;
    r = $random(seed);
    return int'($signed(r[7:0])) >>> shift;  // shift narrows the range
  endfunction

  function automatic word_t weight_word(input int i);
    word_t w;
    int    j;
    for (j = 0; j < `FC_LANES; j++) begin
      w[8*j +: 8] = 8'(w_v[i][j]);
    end
    return w;
  endfunction

  function automatic word_t bias_word();
    word_t w;
    int    j;
    for (j = 0; j < `FC_LANES; j++) begin
      w[8*j +: 8] = 8'(bias_v[j]);
    end
    return w;
  endfunction

  // dot product plus bias, then relu, clamp and shift
  function automatic word_t model(input int n);
    word_t w;
    int    sum;
    int    i;
    int    j;
    for (j = 0; j < `FC_LANES; j++) begin
      sum = bias_v[j];
      for (i = 0; i < n; i++) begin
        sum += feat_v[i] * w_v[i][j];
      end
      if (sum < 0) begin
        w[8*j +: 8] = 8'd0;
      end else if (sum >= (1 << (`FC_QTOP + 1))) begin
        w[8*j +: 8] = 8'd127;
      end else begin
        w[8*j +: 8] = 8'(sum >>> `FC_QSHIFT);
      end
    end
    return w;
  endfunction

  task automatic fill_random(input int shift);
    int i;
    int j;
    for (i = 0; i < `FC_DEPTH; i++) begin
      feat_v[i] = rand_byte(shift);
      for (j = 0; j < `FC_LANES; j++) begin
        w_v[i][j] = rand_byte(shift);
      end
    end
    for (j = 0; j < `FC_LANES; j++) begin
      bias_v[j] = rand_byte(0);
    end
  endtask

  ////////////////////
  // bus tasks

  task automatic wait_reset();
    int t;
    for (t = 0; t < 50 && rstn !== 1'b1; t++) begin
      @(posedge clk);
      #2;
    end
    if (rstn !== 1'b1) begin
      $display("reset was never released");
      errors++;
    end
  endtask

  // entries 0 to n-1 plus the bias word
  task automatic load(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      feat_we   = 1'b1;
      feat_addr = 6'(i);
      feat_data = 8'(feat_v[i]);
      w_we      = 1'b1;
      w_addr    = 6'(i);
      w_data    = weight_word(i);
      bias_we   = (i == 0);
      bias_data = bias_word();
    end
    @(posedge clk);
    #2;
    feat_we = 1'b0;
    w_we    = 1'b0;
    bias_we = 1'b0;
  endtask

  task automatic start_run(input int n, output bit ok);
    int t;
    ok = 1'b0;
    for (t = 0; t < 200 && !ok; t++) begin
      @(posedge clk);
      #2;
      ok = ready;
    end
    if (ok) begin
      start    = 1'b1;
      feat_len = 7'(n);
      @(posedge clk);
      #2;
      start = 1'b0;
      checks++;
      // the run has begun, so the feeder is busy
      assert (!ready) else begin
        $display("FAIL %0t ns: ready still high in the cycle after start", $time);
        errors++;
      end
    end else begin
      $display("timeout, ready stayed low for 200 cycles");
      errors++;
    end
  endtask

  // out_valid is sampled mid cycle
  task automatic wait_out(output word_t data, output bit ok);
    int t;
    ok   = 1'b0;
    data = '0;
    for (t = 0; t < 300 && !ok; t++) begin
      @(negedge clk);
      if (out_valid) begin
        ok   = 1'b1;
        data = out_data;
      end
    end
    if (!ok) begin
      $display("timeout, no out_valid within 300 cycles");
      errors++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input int n);
    int j;
    for (j = 0; j < `FC_LANES; j++) begin
      checks++;
      assert (got[8*j +: 8] == exp[8*j +: 8]) else begin
        $display("FAIL %0t ns: len %0d lane %0d got %0d expected %0d", $time, n, j,
                 got[8*j +: 8], exp[8*j +: 8]);
        errors++;
      end
    end
  endtask

  task automatic run_and_check(input int n);
    bit    ok;
    word_t got;
    start_run(n, ok);
    if (ok) wait_out(got, ok);
    if (ok) check_word(got, model(n), n);
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == mark) $display("test %0d %s passed", tests, name);
    else $display("test %0d %s had %0d errors", tests, name, errors - mark);
    mark = errors;
  endtask

  ////////////////////
  // tests

  task automatic single_feature_test();
    feat_v[0] = 100;
    w_v[0]    = '{10, 20, 30, 40};
    bias_v    = '{0, 0, 0, 0};
    load(1);
    run_and_check(1);
  endtask

  task automatic random_test();
    int r;
    for (r = 0; r < 3; r++) begin
      fill_random(r == 2 ? 4 : 0);  // last run small enough to stay unclamped
      load(`FC_DEPTH);
      run_and_check(`FC_DEPTH);
    end
  endtask

  task automatic saturate_test();
    int i;
    for (i = 0; i < 4; i++) begin
      feat_v[i] = -128;
      w_v[i]    = '{127, -128, -1, -64};  // lane 3 lands exactly on bit 13
    end
    bias_v = '{0, 0, 0, 0};
    load(4);
    run_and_check(1);  // a single -128 x -128 already clamps
    run_and_check(4);
  endtask

  task automatic bias_step_test();
    int steps [3];
    int k;
    steps     = '{0, 64, -64};
    feat_v[0] = 64;
    w_v[0]    = '{10, 0, 127, -1};
    for (k = 0; k < 3; k++) begin
      bias_v = '{steps[k], steps[k], steps[k], steps[k]};
      load(1);
      run_and_check(1);
    end
  endtask

  task automatic back_to_back_test();
    word_t got [$];
    word_t exp1;
    word_t exp2;
    bit    ok;
    bit    second;
    int    t;
    fill_random(3);
    load(`FC_DEPTH);
    exp1   = model(40);
    exp2   = model(9);
    second = 1'b0;
    start_run(40, ok);
    for (t = 0; ok && t < 300 && got.size() < 2; t++) begin
      if (!second && ready) begin
        start    = 1'b1;   // second run while the first is in the lanes
        feat_len = 7'd9;
        second   = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      if (out_valid) got.push_back(out_data);
      @(posedge clk);
      #2;
    end
    start = 1'b0;
    if (ok && got.size() != 2) begin
      $display("timeout, saw %0d of 2 out_valid pulses", got.size());
      errors++;
    end else if (ok) begin
      check_word(got[0], exp1, 40);
      check_word(got[1], exp2, 9);
    end
  endtask

  initial begin
    feat_we   = 1'b0;
    feat_addr = '0;
    feat_data = '0;
    w_we      = 1'b0;
    w_addr    = '0;
    w_data    = '0;
    bias_we   = 1'b0;
    bias_data = '0;
    start     = 1'b0;
    feat_len  = '0;
    wait_reset();
    single_feature_test();
    report_test("single feature");
    random_test();
    report_test("random full runs");
    saturate_test();
    report_test("relu and saturation");
    bias_step_test();
    report_test("bias step");
    back_to_back_test();
    report_test("back to back runs");
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
src/fc_pkg.sv
src/fc_feeder.sv
src/fc_mult.sv
src/fc_pe.sv
src/fc_drain.sv
src/fc_top.sv
sim/tb_clock.sv
sim/tb_fc.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv sim/*.sv include/*.svh)

obj_dir/Vtb_fc: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_fc -o Vtb_fc

run: obj_dir/Vtb_fc
	@out="$$(./obj_dir/Vtb_fc)"; echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir

.PHONY: run clean
